/* hw/mips_isa_pkg.sv */
package mips_isa_pkg;

    // first fetch address out of reset (kseg1 boot rom)
    localparam logic [31:0] reset_vector = 32'hbfc00000;

    // one instruction word
    localparam logic [31:0] inst_bytes = 32'd4;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;

    // loads
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lh      = 6'h21;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_lhu     = 6'h25;

    // stores
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sh      = 6'h29;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes, inst[5:0]
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_jalr    = 6'h09;

    // coarse class seen by decode
    typedef enum logic [2:0] {
        cls_alu,
        cls_branch,
        cls_jump,
        cls_jump_reg,
        cls_load,
        cls_store
    } inst_class_e;

    // pre-decoded instruction handed to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        inst_class_e cls;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        // static target, zero when not a jump or branch
        logic [31:0] target;
    } decoded_t;

endpackage

/* hw/sram_bus_pkg.sv */
package sram_bus_pkg;

    // top address bits dropped to form the physical address
    // (kseg0/kseg1 fold onto the same physical window)
    localparam int phys_mask_bits = 3;

    // one completed fetch, word plus the pc it came from
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_out_t;

endpackage

/* hw/pc_gen.sv */
`timescale 1ns/1ns

module pc_gen (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        pc_advance,
    output logic [31:0] pc
);
    import mips_isa_pkg::*;

    // redirect wins over a same-cycle advance, the accepted
    // request was on the old path anyway
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (pc_advance) begin
            pc <= pc + inst_bytes;
        end
    end

    // redirect targets come from outside, so alignment is not guaranteed here
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    ) else $error("pc_gen: unaligned pc %h", pc);

endmodule

/* hw/ifetch.sv */
`timescale 1ns/1ns

module ifetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     en,
    input  logic                     redirect,
    input  logic                     stage_free,
    input  logic [31:0]              pc,
    output logic                     pc_advance,
    output logic                     inst_req,
    output logic [31:0]              inst_addr,
    input  logic [31:0]              inst_rdata,
    input  logic                     inst_addr_ok,
    input  logic                     inst_data_ok,
    output logic                     fetch_valid,
    output sram_bus_pkg::fetch_out_t fetch_data
);
    import sram_bus_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_wait_addr,
        s_wait_data
    } state_e;

    state_e      state;
    logic [31:0] req_pc;
    logic        stale;
    logic        can_issue;
    logic        accept;
    logic        rsp_keep;
    logic        buf_valid;
    fetch_out_t  buf_data;
    fetch_out_t  rsp_data;

    // no new request while the buffer is occupied or the pc is about to move
    assign can_issue = en && stage_free && !buf_valid && !redirect;

    assign inst_req   = (state == s_wait_addr);
    assign inst_addr  = {{phys_mask_bits{1'b0}}, req_pc[31-phys_mask_bits:0]};
    assign accept     = inst_req && inst_addr_ok;
    // a stale acceptance must not step past the redirect target
    assign pc_advance = accept && !stale;

    assign rsp_keep = inst_data_ok && !stale && !redirect;
    assign rsp_data = '{pc: req_pc, inst: inst_rdata};

    // buffered word goes ahead of a live one
    assign fetch_valid = stage_free && !redirect && (buf_valid || rsp_keep);
    assign fetch_data  = buf_valid ? buf_data : rsp_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (can_issue) begin
                        state <= s_wait_addr;
                    end
                end
                s_wait_addr: begin
                    if (accept) begin
                        // zero-wait memory answers in the same cycle
                        state <= inst_data_ok ? s_idle : s_wait_data;
                    end
                end
                s_wait_data: begin
                    if (inst_data_ok) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // address is held from issue until the response returns
    always_ff @(posedge clk) begin
        if (state == s_idle && can_issue) begin
            req_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stale <= 1'b0;
        end else if (inst_data_ok) begin
            stale <= 1'b0;
        end else if (redirect && state != s_idle) begin
            stale <= 1'b1;
        end
    end

    // one-entry skid for a response that lands while stage 1 is held
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            buf_valid <= 1'b0;
        end else if (buf_valid) begin
            if (stage_free) begin
                buf_valid <= 1'b0;
            end
        end else if (rsp_keep && !stage_free) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!buf_valid && rsp_keep && !stage_free) begin
            buf_data <= rsp_data;
        end
    end

    // no second request between address acceptance and data
    a_no_req_wait_data: assert property (
        @(posedge clk) disable iff (reset)
        (accept && !inst_data_ok) |=> (!inst_req until_with inst_data_ok)
    ) else $error("ifetch: inst_req raised while waiting for data");

    a_no_data_ok_idle: assert property (
        @(posedge clk) disable iff (reset)
        (state == s_idle) |-> !inst_data_ok
    ) else $error("ifetch: inst_data_ok with no request outstanding");

endmodule

/* hw/stage_reg.sv */
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     hold,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // flush beats hold, the held entry is on a dead path
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves with a valid word
    always_ff @(posedge clk) begin
        if (!hold && in_valid) begin
            out_data <= in_data;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        (hold && out_valid && !flush) |=> (out_valid && $stable(out_data))
    ) else $error("stage_reg: contents changed under hold");

endmodule

/* hw/predecode.sv */
`timescale 1ns/1ns

module predecode (
    input  sram_bus_pkg::fetch_out_t in,
    output mips_isa_pkg::decoded_t   dec
);
    import mips_isa_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [31:0] pc_plus4;
    logic [31:0] jump_target;
    logic [31:0] branch_target;
    inst_class_e cls;

    assign opcode   = in.inst[31:26];
    assign funct    = in.inst[5:0];
    assign pc_plus4 = in.pc + inst_bytes;

    // j/jal stay inside the current 256 MB region of the delay slot
    assign jump_target = {pc_plus4[31:28], in.inst[25:0], 2'b00};

    // word offset relative to the delay slot
    assign branch_target = pc_plus4 + {{14{in.inst[15]}}, in.inst[15:0], 2'b00};

    always_comb begin
        case (opcode)
            op_special: begin
                if (funct == fn_jr || funct == fn_jalr) begin
                    cls = cls_jump_reg;
                end else begin
                    cls = cls_alu;
                end
            end
            op_j, op_jal: begin
                cls = cls_jump;
            end
            // regimm covers bltz/bgez and the linking forms
            op_beq, op_bne, op_blez, op_bgtz, op_regimm: begin
                cls = cls_branch;
            end
            op_lb, op_lh, op_lw, op_lbu, op_lhu: begin
                cls = cls_load;
            end
            op_sb, op_sh, op_sw: begin
                cls = cls_store;
            end
            default: begin
                cls = cls_alu;
            end
        endcase
    end

    always_comb begin
        dec.pc   = in.pc;
        dec.inst = in.inst;
        dec.cls  = cls;
        dec.rs   = in.inst[25:21];
        dec.rt   = in.inst[20:16];
        dec.rd   = in.inst[15:11];
        // jr/jalr targets live in a register, decode resolves them
        case (cls)
            cls_jump:   dec.target = jump_target;
            cls_branch: dec.target = branch_target;
            default:    dec.target = 32'h0;
        endcase
    end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/1ns

module fetch_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    input  logic                   redirect,
    input  logic [31:0]            redirect_pc,
    input  logic                   hold,
    output logic                   inst_req,
    output logic [31:0]            inst_addr,
    input  logic [31:0]            inst_rdata,
    input  logic                   inst_addr_ok,
    input  logic                   inst_data_ok,
    output logic                   out_valid,
    output mips_isa_pkg::decoded_t out
);
    import mips_isa_pkg::*;
    import sram_bus_pkg::*;

    logic        pc_advance;
    logic [31:0] pc;
    logic        stage_free;
    logic        s1_hold;
    logic        fetch_valid;
    fetch_out_t  fetch_data;
    logic        s1_valid;
    fetch_out_t  s1_data;
    decoded_t    s1_dec;

    // stage 1 holds only when it has something and stage 2 holds
    assign s1_hold    = hold && s1_valid;
    assign stage_free = !s1_hold;

    pc_gen u_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc_advance  (pc_advance),
        .pc          (pc)
    );

    ifetch u_ifetch (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .redirect     (redirect),
        .stage_free   (stage_free),
        .pc           (pc),
        .pc_advance   (pc_advance),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data)
    );

    stage_reg #(.payload_t(fetch_out_t)) u_stage1 (
        .clk       (clk),
        .reset     (reset),
        .flush     (redirect),
        .hold      (s1_hold),
        .in_valid  (fetch_valid),
        .in_data   (fetch_data),
        .out_valid (s1_valid),
        .out_data  (s1_data)
    );

    predecode u_predecode (
        .in  (s1_data),
        .dec (s1_dec)
    );

    stage_reg #(.payload_t(decoded_t)) u_stage2 (
        .clk       (clk),
        .reset     (reset),
        .flush     (redirect),
        .hold      (hold),
        .in_valid  (s1_valid),
        .in_data   (s1_dec),
        .out_valid (out_valid),
        .out_data  (out)
    );

endmodule

/* dv/imem_model.sv */
`timescale 1ns/1ns

module imem_model #(
    parameter logic [15:0][31:0] prog_words = '0,
    parameter logic [31:0]       seed       = 32'h1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_req,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    output logic        inst_addr_ok,
    output logic        inst_data_ok
);
    int unsigned addr_wait;
    int unsigned data_wait;
    logic        addr_armed;
    logic        data_pending;
    logic [31:0] data_addr;

    function automatic logic [31:0] word_at(input logic [31:0] paddr);
        // program window sits at the boot rom
        if (paddr[31:6] == 26'h07f0000) begin
            return prog_words[paddr[5:2]];
        end
        // elsewhere a hash of the whole address
        return paddr * 32'h9e3779b1;
    endfunction

    // strobes change on the falling edge, the DUT samples on the rising one
    initial begin
        void'($urandom(seed));
        inst_rdata   = 32'h0;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        addr_armed   = 1'b0;
        data_pending = 1'b0;
        addr_wait    = 0;
        data_wait    = 0;
        data_addr    = 32'h0;
        forever begin
            @(negedge clk);
            inst_addr_ok = 1'b0;
            inst_data_ok = 1'b0;
            if (reset) begin
                addr_armed   = 1'b0;
                data_pending = 1'b0;
            end else if (data_pending) begin
                if (data_wait == 0) begin
                    inst_data_ok = 1'b1;
                    inst_rdata   = word_at(data_addr);
                    data_pending = 1'b0;
                end else begin
                    data_wait--;
                end
            end else if (inst_req) begin
                // 0 to 2 cycles until the address is taken
                if (!addr_armed) begin
                    addr_wait  = $urandom % 3;
                    addr_armed = 1'b1;
                end
                if (addr_wait == 0) begin
                    inst_addr_ok = 1'b1;
                    addr_armed   = 1'b0;
                    data_addr    = inst_addr;
                    // 0 to 3 cycles from acceptance to data
                    data_wait    = $urandom % 4;
                    if (data_wait == 0) begin
                        inst_data_ok = 1'b1;
                        inst_rdata   = word_at(data_addr);
                    end else begin
                        data_wait--;
                        data_pending = 1'b1;
                    end
                end else begin
                    addr_wait--;
                end
            end
        end
    end

endmodule

/* dv/fetch_checker.sv */
`timescale 1ns/1ns

module fetch_checker #(
    parameter logic [15:0][31:0] prog_words = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    input  logic                   redirect,
    input  logic [31:0]            redirect_pc,
    input  logic                   hold,
    input  logic                   inst_req,
    input  logic [31:0]            inst_addr,
    input  logic                   out_valid,
    input  mips_isa_pkg::decoded_t out,
    output int                     err_count,
    output int                     out_count
);
    import mips_isa_pkg::*;

    // generous bound for the pipe to empty with en and hold low
    localparam int drain_cycles = 16;

    logic [31:0] exp_pc;
    logic        held_q;
    logic        req_q;
    logic        en_q;
    decoded_t    out_q;
    int          quiet_cycles;

    function automatic logic [31:0] word_at(input logic [31:0] paddr);
        if (paddr[31:6] == 26'h07f0000) begin
            return prog_words[paddr[5:2]];
        end
        return paddr * 32'h9e3779b1;
    endfunction

    // expected record for a pc from the ISA encoding
    function automatic decoded_t expect_dec(input logic [31:0] pc);
        decoded_t    d;
        logic [31:0] w;
        logic [31:0] seq_pc;
        logic [31:0] offset;
        logic [5:0]  op;
        w        = word_at({3'b000, pc[28:0]});
        seq_pc   = pc + 32'd4;
        offset   = {{16{w[15]}}, w[15:0]} << 2;
        op       = w[31:26];
        d.pc     = pc;
        d.inst   = w;
        d.rs     = w[25:21];
        d.rt     = w[20:16];
        d.rd     = w[15:11];
        d.cls    = cls_alu;
        d.target = 32'h0;
        if (op == op_special && (w[5:0] == fn_jr || w[5:0] == fn_jalr)) begin
            d.cls = cls_jump_reg;
        end else if (op == op_j || op == op_jal) begin
            d.cls    = cls_jump;
            d.target = {seq_pc[31:28], w[25:0], 2'b00};
        end else if (op inside {op_beq, op_bne, op_blez, op_bgtz, op_regimm}) begin
            d.cls    = cls_branch;
            d.target = seq_pc + offset;
        end else if (op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu}) begin
            d.cls = cls_load;
        end else if (op inside {op_sb, op_sh, op_sw}) begin
            d.cls = cls_store;
        end
        return d;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("FAILED %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
            err_count++;
        end
    endtask

    task automatic compare_dec(input decoded_t exp_dec, input decoded_t act_dec);
        compare_field("out.pc", exp_dec.pc, act_dec.pc);
        compare_field("out.inst", exp_dec.inst, act_dec.inst);
        compare_field("out.cls", 32'(exp_dec.cls), 32'(act_dec.cls));
        compare_field("out.rs", 32'(exp_dec.rs), 32'(act_dec.rs));
        compare_field("out.rt", 32'(exp_dec.rt), 32'(act_dec.rt));
        compare_field("out.rd", 32'(exp_dec.rd), 32'(act_dec.rd));
        compare_field("out.target", exp_dec.target, act_dec.target);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_pc       = reset_vector;
            held_q       = 1'b0;
            req_q        = 1'b0;
            en_q         = en;
            quiet_cycles = 0;
            err_count    = 0;
            out_count    = 0;
        end else begin
            // a held output must not move or vanish
            if (held_q) begin
                if (!out_valid) begin
                    $display("out_valid dropped while hold was high at %0t", $time);
                    err_count++;
                end else begin
                    compare_dec(out_q, out);
                end
            end
            // decode takes a word on every edge with hold low
            if (redirect) begin
                exp_pc = redirect_pc;
            end else if (out_valid && !hold) begin
                compare_dec(expect_dec(exp_pc), out);
                exp_pc = exp_pc + 32'd4;
                out_count++;
            end
            // bus address carries no segment bits
            if (inst_req) begin
                compare_field("inst_addr[31:29]", 32'h0, 32'(inst_addr[31:29]));
            end
            if (inst_req && !req_q && !en_q) begin
                $display("new bus request started with en low at %0t", $time);
                err_count++;
            end
            if (!en && !hold) begin
                quiet_cycles++;
            end else begin
                quiet_cycles = 0;
            end
            if (quiet_cycles > drain_cycles && out_valid) begin
                $display("outputs still coming long after en fell at %0t", $time);
                err_count++;
            end
            held_q = out_valid && hold && !redirect;
            req_q  = inst_req;
            en_q   = en;
            out_q  = out;
        end
    end

endmodule

/* dv/fetch_tb.sv */
`timescale 1ns/1ns

module fetch_tb;
    import mips_isa_pkg::*;

    typedef struct packed {
        logic [15:0] cycles;
        logic        en;
        logic        hold;
        logic        redir;
        logic [31:0] redir_pc;
    } stim_t;

    // one word of every class at physical 0x1fc00000
    localparam logic [15:0][31:0] prog_words = {
        32'h19e00004, // 15 blez
        32'h95cd0006, // 14 lhu
        32'h0580fff8, // 13 bltz
        32'ha56a0002, // 12 sh
        32'h0120f809, // 11 jalr
        32'h1d000002, // 10 bgtz
        32'h80e6ffff, // 9  lb
        32'h0c000040, // 8  jal
        32'h14850010, // 7  bne
        32'h03e00008, // 6  jr
        32'h00221821, // 5  addu
        32'h0bf00008, // 4  j
        32'hac620004, // 3  sw
        32'h1022fffd, // 2  beq
        32'h8c220008, // 1  lw
        32'h24010005  // 0  addiu
    };

    localparam int n_steps    = 14;
    localparam int tail_insts = 12;

    // cycles, en, hold, redirect, target
    localparam stim_t stim_table [n_steps] = '{
        '{16'd40, 1'b1, 1'b0, 1'b0, 32'h0},
        '{16'd12, 1'b1, 1'b1, 1'b0, 32'h0},
        '{16'd30, 1'b1, 1'b0, 1'b1, 32'hbfc00010},
        '{16'd6,  1'b1, 1'b1, 1'b0, 32'h0},
        '{16'd3,  1'b1, 1'b0, 1'b0, 32'h0},
        '{16'd5,  1'b1, 1'b1, 1'b0, 32'h0},
        '{16'd2,  1'b1, 1'b0, 1'b1, 32'h9fc00020},
        '{16'd25, 1'b1, 1'b0, 1'b1, 32'h80000400},
        '{16'd30, 1'b0, 1'b0, 1'b0, 32'h0},
        '{16'd8,  1'b1, 1'b1, 1'b1, 32'hbfc00030},
        '{16'd20, 1'b1, 1'b0, 1'b0, 32'h0},
        '{16'd10, 1'b0, 1'b1, 1'b0, 32'h0},
        '{16'd20, 1'b0, 1'b0, 1'b0, 32'h0},
        '{16'd30, 1'b1, 1'b0, 1'b1, 32'hbfc00000}
    };

    logic        clk;
    logic        reset;
    logic        en;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        hold;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic        out_valid;
    decoded_t    dec_out;
    int          err_count;
    int          out_count;

    function automatic int table_cycles();
        int total;
        total = 0;
        foreach (stim_table[i]) begin
            total += stim_table[i].cycles;
        end
        return total;
    endfunction

    fetch_top DUT (
        .clk          (clk),
        .reset        (reset),
        .en           (en),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .hold         (hold),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .out_valid    (out_valid),
        .out          (dec_out)
    );

    imem_model #(.prog_words(prog_words), .seed(32'hb314)) u_imem (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok)
    );

    fetch_checker #(.prog_words(prog_words)) u_checker (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .hold        (hold),
        .inst_req    (inst_req),
        .inst_addr   (inst_addr),
        .out_valid   (out_valid),
        .out         (dec_out),
        .err_count   (err_count),
        .out_count   (out_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        stim_t step;
        int    base;
        reset       = 1'b1;
        en          = 1'b0;
        hold        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = 32'h0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            step        = stim_table[i];
            en          = step.en;
            hold        = step.hold;
            redirect    = step.redir;
            redirect_pc = step.redir_pc;
            // redirect is a single-cycle pulse
            repeat (step.cycles) begin
                @(negedge clk);
                redirect = 1'b0;
            end
        end
        // free run until a few more instructions come out
        en   = 1'b1;
        hold = 1'b0;
        base = out_count;
        while (out_count < base + tail_insts) begin
            @(negedge clk);
        end
        @(negedge clk);
        $display("fetch_tb: %0d outputs checked, %0d errors", out_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the stimulus table and the tail
    initial begin
        int cycles;
        int limit;
        cycles = 0;
        limit  = table_cycles() + 8 * tail_insts + 100;
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("fetch_tb: %0d outputs checked, %0d errors", out_count, err_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb.f */
hw/mips_isa_pkg.sv
hw/sram_bus_pkg.sv
hw/pc_gen.sv
hw/ifetch.sv
hw/stage_reg.sv
hw/predecode.sv
hw/fetch_top.sv
dv/imem_model.sv
dv/fetch_checker.sv
dv/fetch_tb.sv
